//--- design/addr_gen_defs.svh
`ifndef ADDR_GEN_DEFS_SVH
`define ADDR_GEN_DEFS_SVH

//////////////////////////////////////////////////
// Memory side widths
//////////////////////////////////////////////////

// Word address width
`define ADDR_W      24
// Burst count width, largest legal count is 64
`define BURST_W     7
// Bytes per memory word
`define DATA_BYTES  8
// Words in one 4 KB page
`define PAGE_WORDS  (4096 / `DATA_BYTES)

// Start state of the burst count LFSR, never zero
`define LFSR_SEED   16'hace1

//////////////////////////////////////////////////
// Configuration register map
//////////////////////////////////////////////////

`define CFG_MIN     2'd0
`define CFG_MAX     2'd1
`define CFG_MODE    2'd2
`define CFG_START   2'd3

`endif

//--- design/addr_gen_pkg.sv
`include "addr_gen_defs.svh"

package addr_gen_pkg;

   //////////////////////////////////////////////////
   // Address generator types
   //////////////////////////////////////////////////

   // One word address on the memory bus
   typedef logic [`ADDR_W-1:0]  addr_t;

   // Burst length in words
   typedef logic [`BURST_W-1:0] burstcount_t;

   // Configuration register index
   typedef logic [1:0]          cfg_sel_t;

   // Configuration write data as seen on the register port
   typedef logic [31:0]         cfg_data_t;

   // Mode flags
   // Bit 0 pow2_only
   // Bit 1 burst_on_boundary
   // Bit 2 no_4kb_cross
   typedef logic [2:0]          mode_t;

endpackage

//--- design/addr_gen_cfg_regs.sv
`include "addr_gen_defs.svh"

module addr_gen_cfg_regs
(
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      cfg_write,
   input  addr_gen_pkg::cfg_sel_t    cfg_sel,
   input  addr_gen_pkg::cfg_data_t   cfg_data,
   output addr_gen_pkg::burstcount_t min_burst,
   output addr_gen_pkg::burstcount_t max_burst,
   output addr_gen_pkg::mode_t       mode,
   output addr_gen_pkg::addr_t       start_addr,
   output logic                      start_load
);
   import addr_gen_pkg::*;

   // Largest count the memory master accepts
   localparam int unsigned MAX_BURST = 1 << (`BURST_W - 1);

   // Write data squeezed into the legal burst range
   burstcount_t wr_burst;

   // Zero becomes 1, anything above 64 becomes 64
   always_comb
   begin
      if (cfg_data == '0)
         wr_burst = burstcount_t'(1);
      else if (cfg_data > MAX_BURST)
         wr_burst = burstcount_t'(MAX_BURST);
      else
         wr_burst = cfg_data[`BURST_W-1:0];
   end

   //////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         min_burst  <= burstcount_t'(1);
         max_burst  <= burstcount_t'(1);
         mode       <= '0;
         start_addr <= '0;
         start_load <= 1'b0;
      end
      else
      begin
         // One cycle pulse after a start address write
         start_load <= cfg_write && (cfg_sel == `CFG_START);

         if (cfg_write)
         begin
            case (cfg_sel)
               `CFG_MIN:
               begin
                  min_burst <= wr_burst;
                  // Keep the range non-empty
                  if (wr_burst > max_burst)
                     max_burst <= wr_burst;
               end
               `CFG_MAX:
               begin
                  // Max never drops below min
                  if (wr_burst < min_burst)
                     max_burst <= min_burst;
                  else
                     max_burst <= wr_burst;
               end
               `CFG_MODE:
                  mode <= cfg_data[$bits(mode_t)-1:0];
               `CFG_START:
                  start_addr <= cfg_data[`ADDR_W-1:0];
            endcase
         end
      end
   end

endmodule

//--- design/rand_burstcount_gen.sv
`include "addr_gen_defs.svh"

module rand_burstcount_gen
(
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      enable,
   input  addr_gen_pkg::burstcount_t min_burst,
   input  addr_gen_pkg::burstcount_t max_burst,
   input  logic                      pow2_only,
   output logic                      ready,
   output addr_gen_pkg::burstcount_t burstcount
);
   import addr_gen_pkg::*;

   // x^16 + x^14 + x^13 + x^11 + 1, right shifting Galois form
   localparam logic [15:0] LFSR_TAPS = 16'hb400;

   logic [15:0] lfsr;
   logic [15:0] lfsr_next;
   logic        step;

   burstcount_t span;
   burstcount_t span_mask;
   burstcount_t rnd;
   burstcount_t lin_count;
   burstcount_t pow2_floor;
   burstcount_t pow2_min;
   burstcount_t next_count;

   // Highest power of two not above value, zero for zero
   function automatic burstcount_t floor_pow2(input burstcount_t value);
      burstcount_t result;
      result = '0;
      for (int i = 0; i < `BURST_W; i++)
      begin
         if (value[i])
            result = burstcount_t'(1) << i;
      end
      return result;
   endfunction

   // New count on the first cycle out of reset and on every accepted pair
   assign step = !ready || enable;

   assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);

   //////////////////////////////////////////////////
   // Count selection
   //////////////////////////////////////////////////

   always_comb
   begin
      span = max_burst - min_burst;
      // All ones up to the top set bit of the span
      for (int i = 0; i < `BURST_W; i++)
         span_mask[i] = |(span >> i);
      rnd = lfsr[`BURST_W-1:0] & span_mask;
      // Masked value is at most 2*span+1, one fold brings it into range
      if (rnd > span)
         rnd = rnd - span - 1'b1;
      lin_count = min_burst + rnd;

      // Power of two fallback is the smallest one at or above min
      pow2_floor = floor_pow2(lin_count);
      pow2_min   = floor_pow2(min_burst);
      if (pow2_min != min_burst)
         pow2_min = pow2_min << 1;
      // No power of two in range, use max
      if (pow2_min > max_burst)
         pow2_min = max_burst;

      if (!pow2_only)
         next_count = lin_count;
      else if (pow2_floor < min_burst)
         next_count = pow2_min;
      else
         next_count = pow2_floor;
   end

   //////////////////////////////////////////////////
   // State
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         lfsr  <= `LFSR_SEED;
         ready <= 1'b0;
      end
      else if (step)
      begin
         lfsr  <= lfsr_next;
         ready <= 1'b1;
      end
   end

   // Count register follows the LFSR step
   always_ff @(posedge clk)
   begin
      if (step)
         burstcount <= next_count;
   end

endmodule

//--- design/burst_boundary_addr_gen.sv
`include "addr_gen_defs.svh"

module burst_boundary_addr_gen
(
   input  addr_gen_pkg::addr_t       addr_in,
   input  addr_gen_pkg::burstcount_t burstcount,
   input  logic                      burst_on_boundary,
   input  logic                      no_4kb_cross,
   output addr_gen_pkg::addr_t       addr_out
);
   import addr_gen_pkg::*;

   // Word offset bits inside one page
   localparam addr_t PAGE_MASK = addr_t'(`PAGE_WORDS - 1);

   addr_t burst_ext;
   addr_t burst_mask;
   addr_t aligned;
   addr_t page_end;
   logic  is_pow2;

   // Count widened to address width
   assign burst_ext  = addr_t'(burstcount);
   assign burst_mask = burst_ext - 1'b1;
   assign is_pow2    = (burstcount != '0) && ((burst_ext & burst_mask) == '0);

   //////////////////////////////////////////////////
   // Alignment to the burst length
   //////////////////////////////////////////////////

   always_comb
   begin
      // Round up to the next multiple of the count
      if (burst_on_boundary && is_pow2)
         aligned = (addr_in + burst_mask) & ~burst_mask;
      else
         aligned = addr_in;
   end

   //////////////////////////////////////////////////
   // 4 KB page check
   //////////////////////////////////////////////////

   // One past the last word of the burst, relative to the page start
   assign page_end = (aligned & PAGE_MASK) + burst_ext;

   always_comb
   begin
      // Burst would spill into the next page, so start there instead
      if (no_4kb_cross && (page_end > addr_t'(`PAGE_WORDS)))
         addr_out = (aligned | PAGE_MASK) + 1'b1;
      else
         addr_out = aligned;
   end

endmodule

//--- design/seq_addr_gen.sv
module seq_addr_gen
(
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      enable,
   input  addr_gen_pkg::burstcount_t min_burst,
   input  addr_gen_pkg::burstcount_t max_burst,
   input  addr_gen_pkg::mode_t       mode,
   input  addr_gen_pkg::addr_t       start_addr,
   input  logic                      start_load,
   output logic                      ready,
   output addr_gen_pkg::addr_t       addr,
   output addr_gen_pkg::burstcount_t burstcount
);
   import addr_gen_pkg::*;

   // Raw address before boundary adjustment
   addr_t seq_addr;

   logic gen_ready;
   logic gen_enable;
   logic consume;
   logic flag_load;
   // Boundary flags that belong to the pair on show
   logic on_boundary_q;
   logic no_cross_q;

   // Pair is hidden while a new start address goes in
   assign ready      = gen_ready && !start_load;
   assign consume    = enable && ready;
   // Start load also draws a fresh count
   assign gen_enable = enable || start_load;
   // Same condition the count generator steps on
   assign flag_load  = !gen_ready || gen_enable;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         seq_addr      <= '0;
         on_boundary_q <= 1'b0;
         no_cross_q    <= 1'b0;
      end
      else
      begin
         if (start_load)
            seq_addr <= start_addr;
         else if (consume)
            seq_addr <= addr + addr_t'(burstcount);

         // Flags move together with the count
         if (flag_load)
         begin
            on_boundary_q <= mode[1];
            no_cross_q    <= mode[2];
         end
      end
   end

   // Count source, mode bit 0 is pow2_only
   rand_burstcount_gen rand_burstcount
   (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (gen_enable),
      .min_burst  (min_burst),
      .max_burst  (max_burst),
      .pow2_only  (mode[0]),
      .ready      (gen_ready),
      .burstcount (burstcount)
   );

   // Adjusted address shown on the output
   burst_boundary_addr_gen burst_boundary
   (
      .addr_in           (seq_addr),
      .burstcount        (burstcount),
      .burst_on_boundary (on_boundary_q),
      .no_4kb_cross      (no_cross_q),
      .addr_out          (addr)
   );

endmodule

//--- design/addr_gen_top.sv
module addr_gen_top
(
   input  logic                      clk,
   input  logic                      reset_n,
   // Configuration write port
   input  logic                      cfg_write,
   input  addr_gen_pkg::cfg_sel_t    cfg_sel,
   input  addr_gen_pkg::cfg_data_t   cfg_data,
   // Generator control and output pair
   input  logic                      enable,
   output logic                      ready,
   output addr_gen_pkg::addr_t       addr,
   output addr_gen_pkg::burstcount_t burstcount
);
   import addr_gen_pkg::*;

   //////////////////////////////////////////////////
   // Configuration to generator
   //////////////////////////////////////////////////

   burstcount_t min_burst;
   burstcount_t max_burst;
   mode_t       mode;
   addr_t       start_addr;
   logic        start_load;

   addr_gen_cfg_regs cfg_regs
   (
      .clk        (clk),
      .reset_n    (reset_n),
      .cfg_write  (cfg_write),
      .cfg_sel    (cfg_sel),
      .cfg_data   (cfg_data),
      .min_burst  (min_burst),
      .max_burst  (max_burst),
      .mode       (mode),
      .start_addr (start_addr),
      .start_load (start_load)
   );

   // Sequential address stream
   seq_addr_gen seq_gen
   (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (enable),
      .min_burst  (min_burst),
      .max_burst  (max_burst),
      .mode       (mode),
      .start_addr (start_addr),
      .start_load (start_load),
      .ready      (ready),
      .addr       (addr),
      .burstcount (burstcount)
   );

endmodule

//--- testbench/addr_gen_checker.sv
`include "addr_gen_defs.svh"

module addr_gen_checker
(
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      enable,
   input  logic                      ready,
   input  addr_gen_pkg::addr_t       addr,
   input  addr_gen_pkg::burstcount_t burstcount
);
   import addr_gen_pkg::*;

   // Largest legal burst
   localparam int unsigned MAX_COUNT = 1 << (`BURST_W - 1);

   // Assertion failures seen so far
   int unsigned failures = 0;

   //////////////////////////////////////////////////
   // Port checks on the address generator
   //////////////////////////////////////////////////

   // No pair on show in the first cycle out of reset
   ready_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !ready)
      else
      begin
         failures++;
         $error("ready is high in the first cycle after reset");
      end

   // Back-pressure freezes the pair
   stall_holds_pair: assert property (@(posedge clk) disable iff (!reset_n)
      ready && !enable |=> $stable(addr) && $stable(burstcount))
      else
      begin
         failures++;
         $error("pair changed while enable was low");
      end

   // Count always within 1 to 64 when shown
   count_in_range: assert property (@(posedge clk) disable iff (!reset_n)
      ready |-> (burstcount >= 1) && (burstcount <= MAX_COUNT))
      else
      begin
         failures++;
         $error("burst count %0d outside 1 to %0d", burstcount, MAX_COUNT);
      end

endmodule

//--- testbench/addr_gen_tb.sv
`include "addr_gen_defs.svh"

module addr_gen_tb;
   import addr_gen_pkg::*;

   localparam int PAIRS       = 40;
   localparam int RUN_LIMIT   = 2000;
   localparam int READY_LIMIT = 20;

   logic        clk = 1'b0;
   logic        reset_n;
   logic        cfg_write;
   cfg_sel_t    cfg_sel;
   cfg_data_t   cfg_data;
   logic        enable;
   logic        ready;
   addr_t       addr;
   burstcount_t burstcount;

   // Configuration last written
   burstcount_t cur_min;
   burstcount_t cur_max;
   mode_t       cur_mode;
   addr_t       cur_start;
   // Next consumed pair is the first after a start load
   logic        fresh;

   // Compare state
   addr_t       prev_addr;
   burstcount_t prev_count;
   logic        held_valid;
   addr_t       held_addr;
   burstcount_t held_count;
   logic        recording;
   addr_t       log_addr[$];
   burstcount_t log_count[$];
   addr_t       ref_addr[$];
   burstcount_t ref_count[$];

   logic [31:0] rng_state = 32'h26a1_a04e;
   int          errors    = 0;
   int          timeouts  = 0;
   logic        timed_out = 1'b0;

   addr_gen_top uut
   (
      .clk        (clk),
      .reset_n    (reset_n),
      .cfg_write  (cfg_write),
      .cfg_sel    (cfg_sel),
      .cfg_data   (cfg_data),
      .enable     (enable),
      .ready      (ready),
      .addr       (addr),
      .burstcount (burstcount)
   );

   bind addr_gen_top addr_gen_checker port_checks
   (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (enable),
      .ready      (ready),
      .addr       (addr),
      .burstcount (burstcount)
   );

   always #2 clk = ~clk;

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // 32-bit xorshift for the enable pattern
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic is_pow2(input burstcount_t v);
      return $countones(v) == 1;
   endfunction

   // Previous address plus previous count, then alignment and page rules
   function automatic addr_t expected_addr(input addr_t prev, input burstcount_t prev_cnt,
                                           input burstcount_t cnt, input mode_t m);
      int unsigned a;
      int unsigned c;
      a = prev + prev_cnt;
      c = cnt;
      // Round up to a multiple of the new count
      if (m[1] && is_pow2(cnt) && (a % c) != 0)
         a = (a / c + 1) * c;
      // Burst would run past the page end
      if (m[2] && (a % `PAGE_WORDS) + c > `PAGE_WORDS)
         a = (a / `PAGE_WORDS + 1) * `PAGE_WORDS;
      return addr_t'(a);
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         errors++;
         $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, actual, expected);
      end
   endtask

   //////////////////////////////////////////////////
   // Comparison of every consumed pair
   //////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (!reset_n)
         held_valid = 1'b0;
      else
      begin
         // Stalled pair must not move
         if (held_valid)
         begin
            check_value(addr, held_addr, "stalled address");
            check_value(burstcount, held_count, "stalled burst count");
         end
         if (ready && enable)
         begin
            if (fresh)
               check_value(addr, expected_addr(cur_start, '0, burstcount, cur_mode), "address");
            else
               check_value(addr, expected_addr(prev_addr, prev_count, burstcount, cur_mode),
                           "address");
            check_value(burstcount >= cur_min && burstcount <= cur_max, 1, "count range");
            if (cur_mode[0])
               check_value(is_pow2(burstcount), 1, "power of two count");
            if (cur_mode[1] && is_pow2(burstcount))
               check_value(addr % burstcount, 0, "burst alignment");
            if (cur_mode[2])
               check_value((addr % `PAGE_WORDS) + burstcount <= `PAGE_WORDS, 1, "page cross");
            prev_addr  = addr;
            prev_count = burstcount;
            fresh      = 1'b0;
            if (recording)
            begin
               log_addr.push_back(addr);
               log_count.push_back(burstcount);
            end
         end
         held_valid = ready && !enable;
         held_addr  = addr;
         held_count = burstcount;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic apply_reset();
      reset_n   <= 1'b0;
      enable    <= 1'b0;
      cfg_write <= 1'b0;
      repeat (5) @(posedge clk);
      reset_n <= 1'b1;
   endtask

   task automatic wait_ready(input string what);
      int cycles;
      cycles = 0;
      if (timed_out)
         return;
      @(posedge clk);
      while (!ready && cycles < READY_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!ready)
      begin
         $display("Timeout: ready never rose %s", what);
         timeouts++;
         timed_out = 1'b1;
      end
   endtask

   // One-cycle register write
   task automatic write_cfg(input cfg_sel_t sel, input cfg_data_t data);
      @(posedge clk);
      cfg_write <= 1'b1;
      cfg_sel   <= sel;
      cfg_data  <= data;
      @(posedge clk);
      cfg_write <= 1'b0;
   endtask

   // Start address goes last so the new pair uses the whole setup
   task automatic configure(input int mn, input int mx, input mode_t m, input int start);
      if (timed_out)
         return;
      cur_min   = mn;
      cur_max   = mx;
      cur_mode  = m;
      cur_start = start;
      fresh     = 1'b1;
      write_cfg(`CFG_MIN, mn);
      write_cfg(`CFG_MAX, mx);
      write_cfg(`CFG_MODE, m);
      write_cfg(`CFG_START, start);
      wait_ready("after a start address load");
   endtask

   task automatic run_pairs(input int n, input logic stalls);
      int done;
      int cycles;
      done   = 0;
      cycles = 0;
      if (timed_out)
         return;
      while (done < n && cycles < RUN_LIMIT)
      begin
         @(posedge clk);
         cycles++;
         if (ready && enable)
            done++;
         rng_state = xorshift32(rng_state);
         if (done >= n)
            enable <= 1'b0;
         else
            enable <= stalls ? (rng_state[1:0] != 2'b00) : 1'b1;
      end
      if (done < n)
      begin
         $display("Timeout: only %0d of %0d pairs were consumed", done, n);
         timeouts++;
         timed_out = 1'b1;
         enable <= 1'b0;
      end
      // Let the compare process finish the last edge
      @(negedge clk);
   endtask

   task automatic recorded_run(input logic stalls);
      @(posedge clk);
      apply_reset();
      wait_ready("after reset");
      configure(2, 17, 3'b000, 100);
      log_addr.delete();
      log_count.delete();
      recording = 1'b1;
      run_pairs(PAIRS, stalls);
      recording = 1'b0;
   endtask

   initial
   begin
      reset_n    = 1'b0;
      cfg_write  = 1'b0;
      cfg_sel    = '0;
      cfg_data   = '0;
      enable     = 1'b0;
      fresh      = 1'b0;
      held_valid = 1'b0;
      recording  = 1'b0;
      cur_min    = 1;
      cur_max    = 1;
      cur_mode   = '0;
      cur_start  = '0;
      apply_reset();
      wait_ready("after reset");

      // Fixed count of 4 from address 0
      configure(4, 4, 3'b000, 0);
      run_pairs(PAIRS, 1'b1);
      // Linear range
      configure(2, 17, 3'b000, 0);
      run_pairs(PAIRS, 1'b1);
      // Powers of two only
      configure(3, 40, 3'b001, 0);
      run_pairs(PAIRS, 1'b1);
      // Aligned bursts from an odd start
      configure(2, 32, 3'b011, 5);
      run_pairs(PAIRS, 1'b1);
      // Page crossing avoided
      configure(30, 64, 3'b100, 500);
      run_pairs(PAIRS, 1'b1);

      // Same sequence with and without stalls
      recorded_run(1'b0);
      ref_addr  = log_addr;
      ref_count = log_count;
      recorded_run(1'b1);
      if (!timed_out)
      begin
         foreach (ref_addr[i])
         begin
            check_value(log_addr[i], ref_addr[i], "stalled run address");
            check_value(log_count[i], ref_count[i], "stalled run count");
         end
      end

      $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
               errors, timeouts, uut.port_checks.failures);
      if (errors == 0 && timeouts == 0 && uut.port_checks.failures == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- src.f
+incdir+design
design/addr_gen_pkg.sv
design/addr_gen_cfg_regs.sv
design/rand_burstcount_gen.sv
design/burst_boundary_addr_gen.sv
design/seq_addr_gen.sv
design/addr_gen_top.sv
testbench/addr_gen_checker.sv
testbench/addr_gen_tb.sv

//--- Bender.yml
package:
  name: addr_gen

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/addr_gen_pkg.sv
      - design/addr_gen_cfg_regs.sv
      - design/rand_burstcount_gen.sv
      - design/burst_boundary_addr_gen.sv
      - design/seq_addr_gen.sv
      - design/addr_gen_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/addr_gen_checker.sv
      - testbench/addr_gen_tb.sv
